/* design/mem_pkg.sv */
// shared widths, bus encoding and stage packets for the mem subsystem
// byte addresses, 64-bit words; only the word index reaches the memory
// one outstanding load per stage, so 4-bit tags are plenty

package mem_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int xlen = 64;             // data + address width
  localparam int word_offset = 3;       // byte bits inside a word

  typedef logic [4:0] reg_idx_t;
  localparam reg_idx_t zero_reg = 5'd31; // always reads zero

  typedef logic [3:0] tag_t;            // 0 means no tag

  ////////////////////
  // bus commands
  ////////////////////
  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_command_t;

  ////////////////////
  // memory constants
  ////////////////////
  localparam int dmem_words = 256;
  localparam int dmem_idx_bits = $clog2(dmem_words);
  localparam int dmem_latency = 4;      // accept -> data return
  localparam int refresh_period = 16;   // one refused cycle per period
  localparam int refresh_bits = $clog2(refresh_period);

  ////////////////////
  // stage packets
  ////////////////////
  typedef struct packed {
    logic [xlen-1:0] npc;               // carried through only
    logic            valid;
    logic            rd_mem;
    logic            wr_mem;
    logic [xlen-1:0] alu_result;        // address or plain result
    logic [xlen-1:0] rega_value;        // store data
    reg_idx_t        dest_reg_idx;
    logic            halt;
  } ex_mem_packet_t;

  typedef struct packed {
    logic [xlen-1:0] npc;
    logic            valid;
    logic [xlen-1:0] result;
    reg_idx_t        dest_reg_idx;
    logic            halt;
  } mem_wb_packet_t;

endpackage

/* design/dmem_if.sv */
// processor <-> data memory bus, plain strobes and no handshake
// response is valid only in the cycle the command is offered
// ret_tag is zero whenever no load data is returning

`timescale 1ns/1ps

interface dmem_if;
  import mem_pkg::*;

  // processor -> memory
  bus_command_t    command;
  logic [xlen-1:0] addr;
  logic [xlen-1:0] wr_data;

  // memory -> processor
  logic [xlen-1:0] rd_data;   // load data, meaningful only with ret_tag
  tag_t            ret_tag;   // tag of the returning load
  tag_t            response;  // nonzero = command accepted

  modport proc (
    output command, addr, wr_data,
    input  rd_data, ret_tag, response
  );

  modport mem (
    input  command, addr, wr_data,
    output rd_data, ret_tag, response
  );

endinterface

/* design/mem_stage.sv */
// memory-access stage; one outstanding load at most
// the execute packet must be held steady by the outside while stall is high
// a refused load is offered again next cycle, a refused store stalls

`timescale 1ns/1ps

module mem_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  mem_pkg::ex_mem_packet_t ex_packet,
  dmem_if.proc                    bus,
  output mem_pkg::mem_wb_packet_t mem_packet,
  output logic                    stall
);
  import mem_pkg::*;

  tag_t waiting_tag;          // tag of the load in flight, 0 = idle
  logic is_load;
  logic is_store;
  logic tag_back;             // our load's data is on the bus now
  logic tag_update;

  // only valid packets touch memory
  assign is_load  = ex_packet.valid & ex_packet.rd_mem;
  assign is_store = ex_packet.valid & ex_packet.wr_mem;

  assign tag_back = (waiting_tag != '0) && (bus.ret_tag == waiting_tag);

  ////////////////////
  // bus side
  ////////////////////
  // nothing goes out while a load is outstanding
  assign bus.command = (waiting_tag != '0) ? bus_none  :
                       is_store            ? bus_store :
                       is_load             ? bus_load  :
                                             bus_none;
  assign bus.addr    = ex_packet.alu_result;  // ALU computed the address
  assign bus.wr_data = ex_packet.rega_value;

  // load in hand: take the new response (0 if refused or on return)
  assign tag_update = is_load && ((waiting_tag == '0) || tag_back);

  always_ff @(posedge clock) begin
    if (reset) begin
      waiting_tag <= '0;
    end else if (tag_update) begin
      waiting_tag <= bus.response;  // command is bus_none on return, so 0
    end
  end

  ////////////////////
  // stall + result
  ////////////////////
  // loads hold until their own tag comes back
  // stores hold only while refused
  assign stall = (is_load && !tag_back) |
                 (is_store && (bus.response == '0));

  assign mem_packet.npc          = ex_packet.npc;
  assign mem_packet.halt         = ex_packet.halt;
  assign mem_packet.valid        = ex_packet.valid & ~stall;
  assign mem_packet.dest_reg_idx = ex_packet.dest_reg_idx;
  assign mem_packet.result       = is_load ? bus.rd_data   // returned word
                                           : ex_packet.alu_result;

endmodule

/* design/tagged_dmem.sv */
// data memory with tagged responses and fixed load latency
// word addressed by addr bits above the byte offset; upper bits ignored
// every command is refused in the last cycle of each refresh period
// several loads may be in flight; returns come back in issue order
// reset clears the whole array (contents read zero after reset)

`timescale 1ns/1ps

module tagged_dmem (
  input  logic clock,
  input  logic reset,
  dmem_if.mem  bus
);
  import mem_pkg::*;

  logic [xlen-1:0]         mem_array [dmem_words];
  logic [refresh_bits-1:0] refresh_cnt;
  tag_t                    next_tag;      // 1..15, skips 0
  logic                    refusing;
  logic                    accept;
  logic [dmem_idx_bits-1:0] word_idx;

  // return pipeline, entry 0 loaded on acceptance
  tag_t            ret_tag_pipe  [dmem_latency];
  logic [xlen-1:0] ret_data_pipe [dmem_latency];

  assign word_idx = bus.addr[word_offset +: dmem_idx_bits];

  ////////////////////
  // refresh + accept
  ////////////////////
  assign refusing = (refresh_cnt == refresh_bits'(refresh_period - 1));
  assign accept   = (bus.command != bus_none) && !refusing;

  always_ff @(posedge clock) begin
    if (reset) begin
      refresh_cnt <= '0;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;  // wraps at period
    end
  end

  // tag goes out in the same cycle as the command
  assign bus.response = accept ? next_tag : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      next_tag <= 4'd1;
    end else if (accept) begin
      next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
    end
  end

  ////////////////////
  // storage
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dmem_words; i++) begin
        mem_array[i] <= '0;
      end
    end else if (accept && (bus.command == bus_store)) begin
      mem_array[word_idx] <= bus.wr_data;   // visible next cycle
    end
  end

  ////////////////////
  // load return pipe
  ////////////////////
  // tags carry the control, data is payload only
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < dmem_latency; s++) begin
        ret_tag_pipe[s] <= '0;
      end
    end else begin
      ret_tag_pipe[0] <= (accept && (bus.command == bus_load)) ? bus.response : '0;
      for (int s = 1; s < dmem_latency; s++) begin
        ret_tag_pipe[s] <= ret_tag_pipe[s-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    ret_data_pipe[0] <= mem_array[word_idx];  // sampled at acceptance
    for (int s = 1; s < dmem_latency; s++) begin
      ret_data_pipe[s] <= ret_data_pipe[s-1];
    end
  end

  // last stage faces the bus, dmem_latency cycles after accept
  assign bus.ret_tag = ret_tag_pipe[dmem_latency-1];
  assign bus.rd_data = ret_data_pipe[dmem_latency-1];

endmodule

/* design/writeback_regfile.sv */
// MEM/WB pipeline register plus 32 x xlen register file
// write happens one cycle after the packet is registered
// register 31 is never written and always reads zero
// read port is combinational with no bypass from the pending write

`timescale 1ns/1ps

module writeback_regfile (
  input  logic                     clock,
  input  logic                     reset,
  input  mem_pkg::mem_wb_packet_t  mem_packet,
  output logic                     retire_valid,
  output mem_pkg::reg_idx_t        retire_dest,
  output logic [mem_pkg::xlen-1:0] retire_result,
  output logic                     halt_out,
  input  mem_pkg::reg_idx_t        rd_idx,
  output logic [mem_pkg::xlen-1:0] rd_data
);
  import mem_pkg::*;

  mem_wb_packet_t  wb_q;          // MEM/WB register
  logic [xlen-1:0] regs [32];
  logic            wr_en;

  ////////////////////
  // MEM/WB register
  ////////////////////
  always_ff @(posedge clock) begin
    wb_q <= mem_packet;
    if (reset) begin
      wb_q.valid <= 1'b0;         // only the control bits clear
      wb_q.halt  <= 1'b0;
    end
  end

  assign retire_valid  = wb_q.valid;
  assign retire_dest   = wb_q.dest_reg_idx;
  assign retire_result = wb_q.result;
  assign halt_out      = wb_q.valid & wb_q.halt;  // halt only with a retire

  ////////////////////
  // register file
  ////////////////////
  assign wr_en = wb_q.valid && (wb_q.dest_reg_idx != zero_reg);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_q.dest_reg_idx] <= wb_q.result;
    end
  end

  // zero_reg masked on read too
  assign rd_data = (rd_idx == zero_reg) ? '0 : regs[rd_idx];

endmodule

/* design/mem_subsys_top.sv */
// mem stage + tagged data memory + writeback register file
// execute inputs must stay steady while stall is high
// non-memory ops and accepted stores retire one cycle after the offer
// loads retire one cycle after stall falls

`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                     clock,
  input  logic                     reset,
  // execute stage result
  input  logic                     ex_valid,
  input  logic                     ex_rd_mem,
  input  logic                     ex_wr_mem,
  input  logic                     ex_halt,
  input  logic [mem_pkg::xlen-1:0] ex_npc,
  input  logic [mem_pkg::xlen-1:0] ex_alu_result,
  input  logic [mem_pkg::xlen-1:0] ex_rega_value,
  input  mem_pkg::reg_idx_t        ex_dest_reg_idx,
  output logic                     stall,
  // retire side
  output logic                     retire_valid,
  output mem_pkg::reg_idx_t        retire_dest,
  output logic [mem_pkg::xlen-1:0] retire_result,
  output logic                     halt_out,
  // register read port
  input  mem_pkg::reg_idx_t        rd_idx,
  output logic [mem_pkg::xlen-1:0] rd_data
);
  import mem_pkg::*;

  ex_mem_packet_t ex_packet;
  mem_wb_packet_t mem_packet;

  dmem_if dmem_bus ();

  // pack the execute ports
  assign ex_packet.npc          = ex_npc;
  assign ex_packet.valid        = ex_valid;
  assign ex_packet.rd_mem       = ex_rd_mem;
  assign ex_packet.wr_mem       = ex_wr_mem;
  assign ex_packet.alu_result   = ex_alu_result;
  assign ex_packet.rega_value   = ex_rega_value;
  assign ex_packet.dest_reg_idx = ex_dest_reg_idx;
  assign ex_packet.halt         = ex_halt;

  mem_stage mem_stage_i (
    .clock      (clock),
    .reset      (reset),
    .ex_packet  (ex_packet),
    .bus        (dmem_bus),
    .mem_packet (mem_packet),
    .stall      (stall)
  );

  tagged_dmem dmem_i (
    .clock (clock),
    .reset (reset),
    .bus   (dmem_bus)
  );

  writeback_regfile wb_i (
    .clock         (clock),
    .reset         (reset),
    .mem_packet    (mem_packet),
    .retire_valid  (retire_valid),
    .retire_dest   (retire_dest),
    .retire_result (retire_result),
    .halt_out      (halt_out),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

endmodule

/* bench/mem_subsys_chk.sv */
// bus protocol checks on the mem stage, bound in from the testbench
// sampled on rising edges, quiet while reset is high
// assumes the stage never sees load and store set together
// outstanding loads are rebuilt from command and response history

`timescale 1ns/1ps

module mem_subsys_chk (
  input logic                  clock,
  input logic                  reset,
  input mem_pkg::bus_command_t command,
  input mem_pkg::tag_t         response,
  input logic                  is_load,
  input logic                  is_store,
  input logic                  stall,
  input logic                  out_valid
);
  import mem_pkg::*;

  logic [dmem_latency-1:0] load_hist;     // bit k: load accepted k+1 cycles ago
  logic                    load_taken;
  int                      failures = 0;  // assertion failures so far

  assign load_taken = (command == bus_load) && (response != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      load_hist <= '0;
    end else begin
      load_hist <= {load_hist[dmem_latency-2:0], load_taken};
    end
  end

  // one load in flight, so the bus stays quiet until it returns
  quiet_while_waiting: assert property (
    @(posedge clock) disable iff (reset)
    (load_hist != '0) |-> (command == bus_none)
  ) else begin
    failures++;
    $error("command %0d issued while a load is outstanding", command);
  end

  // a stalled load leaves only with its own data return
  load_leaves_on_return: assert property (
    @(posedge clock) disable iff (reset)
    (is_load && out_valid) |-> load_hist[dmem_latency-1]
  ) else begin
    failures++;
    $error("load left the stage without a data return %0d cycles after accept",
           dmem_latency);
  end

  // refresh refuses a single cycle, so a stalled store goes through next
  store_stall_refused: assert property (
    @(posedge clock) disable iff (reset)
    (is_store && stall) |=> (response != '0)
  ) else begin
    failures++;
    $error("store refused twice in a row");
  end

endmodule

/* bench/mem_subsys_tb.sv */
// table-driven testbench for mem_subsys_top
// fixed entries first, then a random load/store/alu mix over 8 words
// expected values come from a reference memory and register array
// inputs change on rising edges, outputs are sampled on falling edges
// stores retire their address as result, like any non-load op

`timescale 1ns/1ps

module mem_subsys_tb;
  import mem_pkg::*;

  localparam int n_fixed     = 8;
  localparam int n_entries   = n_fixed + 40;
  localparam int op_alu      = 0;
  localparam int op_load     = 1;
  localparam int op_store    = 2;
  localparam int watchdog_ns = n_entries * (dmem_latency + refresh_period + 4) * 20;

  logic            clock = 1'b0;
  logic            reset;
  logic            ex_valid, ex_rd_mem, ex_wr_mem, ex_halt;
  logic [xlen-1:0] ex_npc, ex_alu_result, ex_rega_value;
  reg_idx_t        ex_dest_reg_idx, rd_idx, retire_dest;
  logic            stall, retire_valid, halt_out;
  logic [xlen-1:0] retire_result, rd_data;

  // stimulus table, one row per operation
  int              tbl_kind  [n_entries];
  logic [xlen-1:0] tbl_addr  [n_entries];
  logic [xlen-1:0] tbl_wdata [n_entries];
  logic [xlen-1:0] tbl_alu   [n_entries];
  reg_idx_t        tbl_dest  [n_entries];
  logic            tbl_halt  [n_entries];

  logic [xlen-1:0] ref_mem  [dmem_words];   // reference memory
  logic [xlen-1:0] ref_regs [32];

  // retire side expected at the next falling edge
  logic            exp_valid;
  reg_idx_t        exp_dest;
  logic [xlen-1:0] exp_result;
  logic            exp_halt;

  logic [31:0] rnd, rnd2;
  int          seed   = 86;
  int          errors = 0;
  int          checks = 0;

  always #10 clock = ~clock;   // 20 ns period

  mem_subsys_top dut_i (.*);

  bind mem_stage mem_subsys_chk chk_i (
    .clock(clock), .reset(reset), .command(bus.command), .response(bus.response),
    .is_load(is_load), .is_store(is_store), .stall(stall),
    .out_valid(mem_packet.valid)
  );

  ////////////////////
  // helpers
  ////////////////////
  task automatic set_entry(input int i, input int kind, input logic [xlen-1:0] addr,
                           input logic [xlen-1:0] wdata, input logic [xlen-1:0] alu,
                           input reg_idx_t dest, input logic halt);
    tbl_kind[i]  = kind;
    tbl_addr[i]  = addr;
    tbl_wdata[i] = wdata;
    tbl_alu[i]   = alu;
    tbl_dest[i]  = dest;
    tbl_halt[i]  = halt;
  endtask

  task automatic report_mismatch(input string name, input logic [xlen-1:0] expected,
                                 input logic [xlen-1:0] actual);
    errors++;
    $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
  endtask

  // one sample of the retire ports, clears the expectation
  task automatic check_retire();
    checks++;
    if (retire_valid !== exp_valid) report_mismatch("retire_valid", xlen'(exp_valid),
                                                    xlen'(retire_valid));
    if (exp_valid && retire_dest !== exp_dest) report_mismatch("retire_dest",
                                                 xlen'(exp_dest), xlen'(retire_dest));
    if (exp_valid && retire_result !== exp_result) report_mismatch("retire_result",
                                                     exp_result, retire_result);
    if (halt_out !== (exp_valid & exp_halt)) report_mismatch("halt_out",
                                               xlen'(exp_valid & exp_halt), xlen'(halt_out));
    exp_valid = 1'b0;
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      ex_valid  <= 1'b0;
      ex_rd_mem <= 1'b0;
      ex_wr_mem <= 1'b0;
      ex_halt   <= 1'b0;
      @(negedge clock);
      check_retire();
    end
  endtask

  // sweep the read port against the reference registers
  task automatic check_regfile();
    for (int r = 0; r < 32; r++) begin
      @(posedge clock);
      rd_idx <= reg_idx_t'(r);
      @(negedge clock);
      checks++;
      if (rd_data !== ref_regs[r]) report_mismatch($sformatf("rd_data[%0d]", r),
                                                   ref_regs[r], rd_data);
    end
  endtask

  ////////////////////
  // apply one entry
  ////////////////////
  task automatic apply_entry(input int i);
    int                       wait_cycles;
    logic [dmem_idx_bits-1:0] widx;
    logic [xlen-1:0]          result;
    wait_cycles = 0;
    widx        = tbl_addr[i][word_offset +: dmem_idx_bits];
    @(posedge clock);
    ex_valid        <= 1'b1;
    ex_rd_mem       <= (tbl_kind[i] == op_load);
    ex_wr_mem       <= (tbl_kind[i] == op_store);
    ex_halt         <= tbl_halt[i];
    ex_npc          <= xlen'(4 * (i + 1));
    ex_alu_result   <= (tbl_kind[i] == op_alu) ? tbl_alu[i] : tbl_addr[i];
    ex_rega_value   <= tbl_wdata[i];
    ex_dest_reg_idx <= tbl_dest[i];
    @(negedge clock);
    check_retire();
    while (stall === 1'b1) begin   // inputs held, retire must stay idle
      wait_cycles++;
      @(negedge clock);
      check_retire();
    end
    if (tbl_kind[i] == op_load && wait_cycles < dmem_latency) begin
      errors++;
      $display("ERROR t=%0t: load of entry %0d stalled only %0d cycles", $time, i,
               wait_cycles);
    end
    if ((tbl_kind[i] == op_alu && wait_cycles != 0) ||
        (tbl_kind[i] == op_store && wait_cycles > 1)) begin
      errors++;
      $display("ERROR t=%0t: entry %0d stalled %0d cycles without a reason", $time, i,
               wait_cycles);
    end
    case (tbl_kind[i])
      op_load:  result = ref_mem[widx];
      op_store: begin
        result        = tbl_addr[i];
        ref_mem[widx] = tbl_wdata[i];
      end
      default:  result = tbl_alu[i];
    endcase
    exp_valid  = 1'b1;             // leaves the stage in this cycle
    exp_dest   = tbl_dest[i];
    exp_result = result;
    exp_halt   = tbl_halt[i];
    if (tbl_dest[i] != zero_reg) ref_regs[tbl_dest[i]] = result;
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    reset           = 1'b1;
    ex_valid        = 1'b0;
    ex_rd_mem       = 1'b0;
    ex_wr_mem       = 1'b0;
    ex_halt         = 1'b0;
    ex_npc          = '0;
    ex_alu_result   = '0;
    ex_rega_value   = '0;
    ex_dest_reg_idx = '0;
    rd_idx          = '0;
    exp_valid       = 1'b0;
    foreach (ref_mem[k]) ref_mem[k] = '0;
    foreach (ref_regs[k]) ref_regs[k] = '0;
    set_entry(0, op_store, 64'h10, 64'hdead_beef_0123_4567, '0, zero_reg, 1'b0);
    set_entry(1, op_load, 64'h10, '0, '0, 5'd5, 1'b0);          // same word as store
    set_entry(2, op_alu, '0, '0, 64'h1234_5678, 5'd6, 1'b0);
    set_entry(3, op_alu, '0, '0, 64'h55, zero_reg, 1'b0);       // r31 stays zero
    set_entry(4, op_store, 64'h18, 64'h0bad_cafe_0000_0018, '0, 5'd9, 1'b0);
    set_entry(5, op_load, 64'h18, '0, '0, zero_reg, 1'b0);
    set_entry(6, op_load, 64'h20, '0, '0, 5'd7, 1'b0);          // never written
    set_entry(7, op_alu, '0, '0, 64'hfeed_f00d, 5'd8, 1'b1);    // halt
    for (int i = n_fixed; i < n_entries; i++) begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      set_entry(i, (rnd[1:0] == 2'd0) ? op_alu : (rnd[1] ? op_load : op_store),
                {58'd0, rnd[4:2], 3'b000}, {rnd2, rnd}, {rnd, ~rnd2}, rnd[9:5], 1'b0);
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    checks++;
    if (stall !== 1'b0) report_mismatch("stall", '0, xlen'(stall));
    check_retire();                // nothing retiring after reset
    check_regfile();
    for (int i = 0; i < n_fixed; i++) apply_entry(i);
    drive_idle(3);
    check_regfile();
    for (int i = n_fixed; i < n_entries; i++) apply_entry(i);
    drive_idle(3);
    check_regfile();
    errors += dut_i.mem_stage_i.chk_i.failures;
    $display("mem_subsys_tb: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog, scaled to the table length
  initial begin
    #(watchdog_ns);
    $display("ERROR: no progress after %0d ns, the DUT appears to hang", watchdog_ns);
    $display("Test failed");
    $finish;
  end

endmodule

/* tb.f */
design/mem_pkg.sv
design/dmem_if.sv
design/mem_stage.sv
design/tagged_dmem.sv
design/writeback_regfile.sv
design/mem_subsys_top.sv
bench/mem_subsys_chk.sv
bench/mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
# build and run the mem subsystem testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module mem_subsys_tb \
  -f tb.f -Mdir obj_dir -o mem_subsys_sim > build.log 2>&1 \
  || { cat build.log; echo "build error"; exit 1; }
./obj_dir/mem_subsys_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
